//--- frame_settings.svh
`ifndef FRAME_SETTINGS_SVH
`define FRAME_SETTINGS_SVH

// fifo holds 2**5 = 32 entries
`define FRAME_FIFO_ADDR_WIDTH 5

// longest good frame, checksum byte included
`define FRAME_MAX_LEN 16

`endif

//--- frame_pkg.sv
`default_nettype none
`include "frame_settings.svh"

package frame_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [`FRAME_FIFO_ADDR_WIDTH:0] fifo_ptr_t; // extra wrap bit
  typedef logic [4:0] frame_len_t;   // saturates at max len + 1
  typedef logic [15:0] frame_count_t;

  typedef enum logic {
    FIFO_ACCEPT,
    FIFO_DISCARD
  } fifo_state_t;

endpackage

`default_nettype wire

//--- frame_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "frame_settings.svh"

module frame_checker
  import frame_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  byte_t        in_data,
  input  logic         in_valid,
  input  logic         in_last,
  output logic         in_ready,
  output byte_t        chk_data,
  output logic         chk_valid,
  output logic         chk_last,
  output logic         chk_bad,
  input  logic         chk_ready,
  output frame_count_t bad_frames
);

  localparam frame_len_t MAX_LEN = frame_len_t'(`FRAME_MAX_LEN);
  localparam frame_len_t LEN_SAT = frame_len_t'(`FRAME_MAX_LEN + 1);
  localparam frame_len_t MIN_LEN = frame_len_t'(2);

  byte_t      sum;      // payload bytes seen so far
  frame_len_t len;      // bytes accepted before the current one
  frame_len_t len_next;
  logic       accept;
  logic       frame_bad;

  assign in_ready = ~chk_valid | chk_ready;
  assign accept   = in_valid & in_ready;

  // stop counting once the frame is known to be too long
  assign len_next = (len == LEN_SAT) ? len : len + 1'b1;

  // only meaningful on the last byte, which carries the checksum
  assign frame_bad = (len_next < MIN_LEN) | (len_next > MAX_LEN) | (sum != in_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_valid  <= 1'b0;
      sum        <= '0;
      len        <= '0;
      bad_frames <= '0;
    end else begin
      if (accept) begin
        chk_valid <= 1'b1;
        if (in_last) begin
          sum <= '0;
          len <= '0;
          if (frame_bad) begin
            bad_frames <= bad_frames + 1'b1;
          end
        end else begin
          sum <= sum + in_data;
          len <= len_next;
        end
      end else if (chk_ready) begin
        chk_valid <= 1'b0; // output taken, nothing new
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      chk_data <= in_data;
      chk_last <= in_last;
      chk_bad  <= in_last & frame_bad;
    end
  end

endmodule

`default_nettype wire

//--- frame_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "frame_settings.svh"

module frame_fifo
  import frame_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  byte_t        chk_data,
  input  logic         chk_valid,
  input  logic         chk_last,
  input  logic         chk_bad,
  output logic         chk_ready,
  output byte_t        fifo_data,
  output logic         fifo_valid,
  output logic         fifo_last,
  input  logic         fifo_ready,
  output frame_count_t overflow_frames
);

  localparam int AW    = `FRAME_FIFO_ADDR_WIDTH;
  localparam int DEPTH = 1 << AW;

  logic [8:0]  mem [DEPTH]; // {last, data}
  fifo_ptr_t   wr_ptr;      // end of last committed frame
  fifo_ptr_t   wr_ptr_cur;  // next write slot of the frame in progress
  fifo_ptr_t   rd_ptr;
  fifo_state_t wr_state;
  logic        full;
  logic        empty;
  logic        read;

  // drop-when-full, so the write side never stalls
  assign chk_ready = 1'b1;

  assign full  = (wr_ptr_cur[AW] != rd_ptr[AW]) &&
                 (wr_ptr_cur[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr); // only committed data is visible
  assign read  = (fifo_ready | ~fifo_valid) & ~empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr          <= '0;
      wr_ptr_cur      <= '0;
      wr_state        <= FIFO_ACCEPT;
      overflow_frames <= '0;
    end else if (chk_valid) begin
      if (wr_state == FIFO_DISCARD || full) begin
        if (chk_last) begin
          wr_ptr_cur <= wr_ptr; // rewind the partial frame
          wr_state   <= FIFO_ACCEPT;
          if (!chk_bad) begin
            overflow_frames <= overflow_frames + 1'b1;
          end
        end else begin
          wr_state <= FIFO_DISCARD;
        end
      end else if (chk_last && chk_bad) begin
        wr_ptr_cur <= wr_ptr; // already counted by the checker
      end else begin
        wr_ptr_cur <= wr_ptr_cur + 1'b1;
        if (chk_last) begin
          wr_ptr <= wr_ptr_cur + 1'b1; // commit
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (chk_valid && wr_state == FIFO_ACCEPT && !full) begin
      mem[wr_ptr_cur[AW-1:0]] <= {chk_last, chk_data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (read) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      {fifo_last, fifo_data} <= mem[rd_ptr[AW-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_valid <= 1'b0;
    end else if (fifo_ready | ~fifo_valid) begin
      fifo_valid <= ~empty;
    end
  end

endmodule

`default_nettype wire

//--- checksum_stripper.sv
`timescale 1ns/100ps
`default_nettype none

module checksum_stripper
  import frame_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  byte_t        fifo_data,
  input  logic         fifo_valid,
  input  logic         fifo_last,
  output logic         fifo_ready,
  output byte_t        out_data,
  output logic         out_valid,
  output logic         out_last,
  input  logic         out_ready,
  output frame_count_t good_frames
);

  byte_t hold_data;
  logic  hold_full;
  logic  take;     // byte consumed from the fifo
  logic  out_xfer;

  // held byte only leaves once its successor is present
  assign out_data  = hold_data;
  assign out_valid = hold_full & fifo_valid;
  assign out_last  = fifo_last; // successor is the checksum

  assign fifo_ready = ~hold_full | out_ready;
  assign take       = fifo_valid & fifo_ready;
  assign out_xfer   = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_full <= 1'b0;
    end else if (take) begin
      // a last byte is the checksum and is never held
      hold_full <= ~fifo_last;
    end
  end

  always_ff @(posedge clk) begin
    if (take && !fifo_last) begin
      hold_data <= fifo_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      good_frames <= '0;
    end else if (out_xfer && out_last) begin
      good_frames <= good_frames + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- frame_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module frame_rx_top
  import frame_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  byte_t        in_data,
  input  logic         in_valid,
  output logic         in_ready,
  input  logic         in_last,
  output byte_t        out_data,
  output logic         out_valid,
  input  logic         out_ready,
  output logic         out_last,
  output frame_count_t bad_frames,
  output frame_count_t overflow_frames,
  output frame_count_t good_frames
);

  byte_t chk_data;
  logic  chk_valid;
  logic  chk_last;
  logic  chk_bad;
  logic  chk_ready;

  byte_t fifo_data;
  logic  fifo_valid;
  logic  fifo_last;
  logic  fifo_ready;

  frame_checker frame_checker_inst (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_ready   (in_ready),
    .chk_data   (chk_data),
    .chk_valid  (chk_valid),
    .chk_last   (chk_last),
    .chk_bad    (chk_bad),
    .chk_ready  (chk_ready),
    .bad_frames (bad_frames)
  );

  frame_fifo frame_fifo_inst (
    .clk             (clk),
    .rst             (rst),
    .chk_data        (chk_data),
    .chk_valid       (chk_valid),
    .chk_last        (chk_last),
    .chk_bad         (chk_bad),
    .chk_ready       (chk_ready),
    .fifo_data       (fifo_data),
    .fifo_valid      (fifo_valid),
    .fifo_last       (fifo_last),
    .fifo_ready      (fifo_ready),
    .overflow_frames (overflow_frames)
  );

  checksum_stripper checksum_stripper_inst (
    .clk         (clk),
    .rst         (rst),
    .fifo_data   (fifo_data),
    .fifo_valid  (fifo_valid),
    .fifo_last   (fifo_last),
    .fifo_ready  (fifo_ready),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .out_last    (out_last),
    .out_ready   (out_ready),
    .good_frames (good_frames)
  );

endmodule

`default_nettype wire

//--- tb_frame_rx.sv
`timescale 1ns/100ps
`default_nettype none
`include "frame_settings.svh"

module tb_frame_rx
  import frame_pkg::*;
();

  localparam int TIMEOUT = 2000; // cycles per wait

  logic         clk;
  logic         rst;
  byte_t        in_data;
  logic         in_valid;
  logic         in_ready;
  logic         in_last;
  byte_t        out_data;
  logic         out_valid;
  logic         out_ready;
  logic         out_last;
  frame_count_t bad_frames;
  frame_count_t overflow_frames;
  frame_count_t good_frames;

  byte_t      tx_q[$];   // frame being built and sent
  logic [8:0] exp_q[$];  // {last, data}
  logic [8:0] rx_q[$];
  int         ready_mode; // 0 high, 1 random, 2 low
  int         exp_good;
  int         exp_bad;
  int         exp_overflow;

  frame_rx_top frame_rx_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      case (ready_mode)
        1: out_ready = ($urandom % 4) != 0; // ready 3 cycles out of 4
        2: out_ready = 1'b0;
        default: out_ready = 1'b1;
      endcase
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      rx_q.push_back({out_last, out_data});
    end
  end

  task automatic abort_run(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
      abort_run({"wrong value on ", name});
    end
  endtask

  // random payload followed by its checksum byte
  task automatic build_frame(input int len, input bit corrupt);
    byte_t sum;
    int    i;
    tx_q.delete();
    sum = 8'h00;
    for (i = 0; i < len - 1; i++) begin
      tx_q.push_back(8'($urandom));
      sum += tx_q[i];
    end
    tx_q.push_back(corrupt ? (sum ^ 8'h5a) : sum);
  endtask

  // good frames leave their payload with the last mark moved back
  task automatic model_frame();
    byte_t sum;
    int    n;
    int    i;
    n   = tx_q.size();
    sum = 8'h00;
    for (i = 0; i < n - 1; i++) begin
      sum += tx_q[i];
    end
    if (n >= 2 && n <= `FRAME_MAX_LEN && sum == tx_q[n-1]) begin
      for (i = 0; i < n - 1; i++) begin
        exp_q.push_back({i == n - 2, tx_q[i]});
      end
      exp_good++;
    end else begin
      exp_bad++;
    end
  endtask

  task automatic send_frame();
    int i;
    int waited;
    for (i = 0; i < tx_q.size(); i++) begin
      in_data  = tx_q[i];
      in_valid = 1'b1;
      in_last  = (i == tx_q.size() - 1);
      waited   = 0;
      @(negedge clk);
      while (!in_ready) begin
        waited++;
        if (waited > TIMEOUT) begin
          abort_run("in_ready stayed low, input stream is stuck");
        end
        @(negedge clk);
      end
      @(posedge clk); // byte taken here
      #1;
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  task automatic transmit_frame(input int len, input bit corrupt);
    build_frame(len, corrupt);
    model_frame();
    send_frame();
  endtask

  task automatic drain_expect();
    int         waited;
    logic [8:0] got;
    logic [8:0] want;
    waited = 0;
    while (rx_q.size() < exp_q.size()) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("output stream delivered too few bytes");
      end
      @(negedge clk);
    end
    while (exp_q.size() > 0) begin
      got  = rx_q.pop_front();
      want = exp_q.pop_front();
      check_eq("out_data", 32'(got[7:0]), 32'(want[7:0]));
      check_eq("out_last", 32'(got[8]), 32'(want[8]));
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_counters();
    check_eq("good_frames", 32'(good_frames), 32'(exp_good));
    check_eq("bad_frames", 32'(bad_frames), 32'(exp_bad));
    check_eq("overflow_frames", 32'(overflow_frames), 32'(exp_overflow));
  endtask

  task automatic test_good_lengths();
    int len;
    for (len = 2; len <= `FRAME_MAX_LEN; len++) begin
      transmit_frame(len, 1'b0);
    end
    drain_expect();
    check_counters();
  endtask

  task automatic test_bad_checksum();
    int k;
    for (k = 0; k < 9; k++) begin
      transmit_frame(2 + int'($urandom % 15), k % 2 == 1); // odd ones corrupted
    end
    drain_expect();
    check_counters();
  endtask

  task automatic test_bad_length();
    frame_count_t start;
    start = bad_frames;
    transmit_frame(5, 1'b0);
    transmit_frame(1, 1'b0);
    transmit_frame(9, 1'b0);
    transmit_frame(`FRAME_MAX_LEN + 1, 1'b0);
    transmit_frame(`FRAME_MAX_LEN, 1'b0);
    drain_expect();
    check_eq("bad_frames increase", 32'(bad_frames - start), 32'd2);
    check_counters();
  endtask

  task automatic test_random_stall();
    int round;
    ready_mode = 1;
    // two frames per round never exceed the fifo
    for (round = 0; round < 6; round++) begin
      transmit_frame(2 + int'($urandom % 15), 1'b0);
      transmit_frame(2 + int'($urandom % 15), 1'b0);
      drain_expect();
    end
    ready_mode = 0;
    check_counters();
  endtask

  task automatic test_overflow();
    int         k;
    int         waited;
    logic [8:0] held;
    ready_mode = 2;
    for (k = 0; k < 4; k++) begin
      build_frame(`FRAME_MAX_LEN, 1'b0);
      if (k < 2) begin
        model_frame();
      end else begin
        exp_overflow++; // no room left for frames 3 and 4
      end
      send_frame();
    end
    waited = 0;
    while (overflow_frames != 16'(exp_overflow)) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("overflow_frames never reached the expected count");
      end
      @(posedge clk);
      #1;
    end
    // first payload byte waits at the output while stalled
    held = exp_q[0];
    check_eq("out_valid", 32'(out_valid), 32'd1);
    check_eq("out_data", 32'(out_data), 32'(held[7:0]));
    check_eq("out_last", 32'(out_last), 32'(held[8]));
    ready_mode = 0;
    drain_expect();
    transmit_frame(7, 1'b0);
    drain_expect();
    check_counters();
  endtask

  initial begin
    void'($urandom(32'hedbd84ff));
    rst          = 1'b1;
    in_data      = 8'h00;
    in_valid     = 1'b0;
    in_last      = 1'b0;
    ready_mode   = 0;
    exp_good     = 0;
    exp_bad      = 0;
    exp_overflow = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    check_eq("out_valid", 32'(out_valid), 32'd0);
    check_eq("in_ready", 32'(in_ready), 32'd1);
    check_counters();

    test_good_lengths();
    test_bad_checksum();
    test_bad_length();
    test_random_stall();
    test_overflow();

    if (rx_q.size() != 0) begin
      abort_run("output stream delivered bytes that no frame accounts for");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
frame_pkg.sv
frame_checker.sv
frame_fifo.sv
checksum_stripper.sv
frame_rx_top.sv
tb_frame_rx.sv

//--- run.sh
#!/usr/bin/env bash
# build the frame receive testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_frame_rx \
    --Mdir obj_dir -o tb_frame_rx_sim \
  && ./obj_dir/tb_frame_rx_sim \
  || { echo "verilator build or simulation returned an error" >&2; exit 1; }
